// File: source/frog_video_defs.svh
`ifndef FROG_VIDEO_DEFS_SVH
`define FROG_VIDEO_DEFS_SVH

// Sprite geometry
`define FV_TILE_SIZE   32
`define FV_BANK_DEPTH  1024   // One 32x32 tile per bank

// Default horizontal mode, 640x480 at 60 Hz
`define FV_H_VISIBLE   640
`define FV_H_FRONT     16
`define FV_H_SYNC      96
`define FV_H_TOTAL     800

// Default vertical mode
`define FV_V_VISIBLE   480
`define FV_V_FRONT     10
`define FV_V_SYNC      2
`define FV_V_TOTAL     525

`endif

// File: source/frog_video_pkg.sv
`default_nettype none

package frog_video_pkg;

    // Raster counter or tile corner
    typedef logic [9:0] coord_t;

    // Word index inside one sprite bank
    typedef logic [9:0] sprite_addr_t;

    // Packed pixel, red [8:6], green [5:3], blue [2:0]
    typedef logic [8:0] pixel_t;

    typedef logic [2:0] chan_t;   // One colour channel

    // 0 selects the frog bank, 1 the car bank
    typedef logic bank_sel_t;

    // Sprite loader FSM
    typedef enum logic [1:0]
    {
        IDLE,
        WAIT_BLANK,
        ACK_HIGH
    } load_state_t;

endpackage

`default_nettype wire

// File: source/sprite_write_if.sv
`timescale 1ns/1ns
`default_nettype none

// Write path from the loader into the sprite banks
interface sprite_write_if;
    import frog_video_pkg::*;

    logic         we;     // One cycle per committed word
    bank_sel_t    bank;
    sprite_addr_t addr;
    pixel_t       data;

    modport loader
    (
        output we, bank, addr, data
    );

    modport memory
    (
        input we, bank, addr, data
    );

endinterface

`default_nettype wire

// File: source/sprite_loader.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_loader
(
    input  wire                       i_Clk,
    input  wire                       i_reset,
    input  wire                       i_load_req,
    input  frog_video_pkg::bank_sel_t    i_load_bank,
    input  frog_video_pkg::sprite_addr_t i_load_addr,
    input  frog_video_pkg::pixel_t       i_load_data,
    output logic                      o_load_ack,
    input  wire                       i_blank,
    sprite_write_if.loader            wr
);
    import frog_video_pkg::*;

    load_state_t  state;
    bank_sel_t    r_bank;
    sprite_addr_t r_addr;
    pixel_t       r_data;

    // Request is taken once, in IDLE
    always_ff @(posedge i_Clk)
    begin
        if (state == IDLE && i_load_req)
        begin
            r_bank <= i_load_bank;
            r_addr <= i_load_addr;
            r_data <= i_load_data;
        end
    end

    always_ff @(posedge i_Clk)
    begin
        if (i_reset)
        begin
            state      <= IDLE;
            o_load_ack <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (i_load_req)
                        state <= WAIT_BLANK;
                end
                WAIT_BLANK:
                begin
                    // Held here while the raster is visible
                    if (i_blank)
                    begin
                        state      <= ACK_HIGH;
                        o_load_ack <= 1'b1;   // Word is written this cycle
                    end
                end
                ACK_HIGH:
                begin
                    if (!i_load_req)
                    begin
                        state      <= IDLE;
                        o_load_ack <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Single write pulse on the first blank cycle
    assign wr.we   = (state == WAIT_BLANK) && i_blank;
    assign wr.bank = r_bank;
    assign wr.addr = r_addr;
    assign wr.data = r_data;

    // Host keeps the word steady until the ack shows up
    a_req_stable: assert property (@(posedge i_Clk) disable iff (i_reset)
        (i_load_req && !o_load_ack) |=>
            (o_load_ack || $stable({i_load_bank, i_load_addr, i_load_data})));

endmodule

`default_nettype wire

// File: source/sprite_memory.sv
`timescale 1ns/1ns
`default_nettype none

`include "frog_video_defs.svh"

module sprite_memory
(
    input  wire                          i_Clk,
    sprite_write_if.memory               wr,
    input  wire                          i_frog_rd_en,
    input  wire                          i_car_rd_en,
    input  frog_video_pkg::sprite_addr_t i_rd_addr,
    output frog_video_pkg::pixel_t       o_frog_pixel,
    output frog_video_pkg::pixel_t       o_car_pixel
);
    import frog_video_pkg::*;

    logic   bank_we    [2];
    logic   bank_rd_en [2];
    pixel_t bank_q     [2];

    assign bank_rd_en[0] = i_frog_rd_en;
    assign bank_rd_en[1] = i_car_rd_en;
    assign o_frog_pixel  = bank_q[0];
    assign o_car_pixel   = bank_q[1];

    // Bank 0 holds the frog, bank 1 the car
    for (genvar b = 0; b < 2; b++)
    begin : g_bank
        pixel_t       mem [`FV_BANK_DEPTH];
        pixel_t       q;
        sprite_addr_t port_addr;

        assign bank_we[b] = wr.we && (wr.bank == bank_sel_t'(b));
        assign port_addr  = bank_we[b] ? wr.addr : i_rd_addr;   // One shared port
        assign bank_q[b]  = q;

        always_ff @(posedge i_Clk)
        begin
            if (bank_we[b])
                mem[port_addr] <= wr.data;
            else if (bank_rd_en[b])
                q <= mem[port_addr];   // Registered read, stage 2
        end

        // Loader only commits where the display has no read in flight
        a_no_rw_clash: assert property (@(posedge i_Clk)
            !(bank_we[b] && bank_rd_en[b]));
    end

endmodule

`default_nettype wire

// File: source/vga_timing.sv
`timescale 1ns/1ns
`default_nettype none

`include "frog_video_defs.svh"

module vga_timing
#(
    parameter int H_VISIBLE = `FV_H_VISIBLE,
    parameter int H_FRONT   = `FV_H_FRONT,
    parameter int H_SYNC    = `FV_H_SYNC,
    parameter int H_TOTAL   = `FV_H_TOTAL,
    parameter int V_VISIBLE = `FV_V_VISIBLE,
    parameter int V_FRONT   = `FV_V_FRONT,
    parameter int V_SYNC    = `FV_V_SYNC,
    parameter int V_TOTAL   = `FV_V_TOTAL
)
(
    input  wire                    i_Clk,
    input  wire                    i_reset,
    output frog_video_pkg::coord_t o_h_count,
    output frog_video_pkg::coord_t o_v_count,
    output logic                   o_hsync,
    output logic                   o_vsync,
    output logic                   o_visible,
    output logic                   o_blank,
    output logic                   o_frame_start
);
    import frog_video_pkg::*;

    localparam coord_t H_LAST     = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST     = coord_t'(V_TOTAL - 1);
    localparam coord_t HS_START   = coord_t'(H_VISIBLE + H_FRONT);
    localparam coord_t HS_END     = coord_t'(H_VISIBLE + H_FRONT + H_SYNC);
    localparam coord_t VS_START   = coord_t'(V_VISIBLE + V_FRONT);
    localparam coord_t VS_END     = coord_t'(V_VISIBLE + V_FRONT + V_SYNC);
    localparam coord_t H_VIS_END  = coord_t'(H_VISIBLE);
    localparam coord_t V_VIS_END  = coord_t'(V_VISIBLE);

    always_ff @(posedge i_Clk)
    begin
        if (i_reset)
        begin
            o_h_count <= '0;
            o_v_count <= '0;
        end
        else if (o_h_count == H_LAST)
        begin
            o_h_count <= '0;
            o_v_count <= (o_v_count == V_LAST) ? '0 : o_v_count + 1'b1;
        end
        else
            o_h_count <= o_h_count + 1'b1;
    end

    // Raw syncs, active low
    assign o_hsync = !(o_h_count >= HS_START && o_h_count < HS_END);
    assign o_vsync = !(o_v_count >= VS_START && o_v_count < VS_END);

    assign o_visible     = (o_h_count < H_VIS_END) && (o_v_count < V_VIS_END);
    assign o_frame_start = (o_h_count == '0) && (o_v_count == '0);

    // Write window, one cycle clear of the visible area on both sides
    // so a display read never lands in the same bank cycle
    assign o_blank = (o_h_count > H_VIS_END && o_h_count < H_LAST) ||
                     (o_v_count >= V_VIS_END &&
                      !(o_v_count == V_LAST && o_h_count == H_LAST));

endmodule

`default_nettype wire

// File: source/sprite_display.sv
`timescale 1ns/1ns
`default_nettype none

`include "frog_video_defs.svh"

module sprite_display
(
    input  wire                          i_Clk,
    input  wire                          i_reset,
    input  frog_video_pkg::coord_t       i_h_count,
    input  frog_video_pkg::coord_t       i_v_count,
    input  wire                          i_visible,
    input  wire                          i_frame_start,
    input  wire                          i_hsync,
    input  wire                          i_vsync,
    input  frog_video_pkg::coord_t       i_frog_x,
    input  frog_video_pkg::coord_t       i_frog_y,
    input  frog_video_pkg::coord_t       i_car_x [4],
    input  frog_video_pkg::coord_t       i_car_y [4],
    output logic                         o_frog_rd_en,
    output logic                         o_car_rd_en,
    output frog_video_pkg::sprite_addr_t o_rd_addr,
    input  frog_video_pkg::pixel_t       i_frog_pixel,
    input  frog_video_pkg::pixel_t       i_car_pixel,
    output logic                         o_vga_hsync,
    output logic                         o_vga_vsync,
    output frog_video_pkg::chan_t        o_vga_red,
    output frog_video_pkg::chan_t        o_vga_grn,
    output frog_video_pkg::chan_t        o_vga_blu
);
    import frog_video_pkg::*;

    localparam coord_t TILE = coord_t'(`FV_TILE_SIZE);

    coord_t       in_x [5];   // Index 0 is the frog, 1..4 the cars
    coord_t       in_y [5];
    coord_t       r_tile_x [5];
    coord_t       r_tile_y [5];
    coord_t       eff_x [5];
    coord_t       eff_y [5];
    coord_t       dx;
    coord_t       dy;
    logic         hit_frog;
    logic         hit_car;
    sprite_addr_t hit_addr;
    logic         r_sel_frog;
    logic         r_sel_car;
    logic [2:0]   r_hs_pipe;
    logic [2:0]   r_vs_pipe;
    pixel_t       pix;

    // Positions in effect this frame; the (0,0) cycle already sees the new ones
    always_comb
    begin
        in_x[0] = i_frog_x;
        in_y[0] = i_frog_y;
        for (int k = 0; k < 4; k++)
        begin
            in_x[k + 1] = i_car_x[k];
            in_y[k + 1] = i_car_y[k];
        end
        for (int k = 0; k < 5; k++)
        begin
            eff_x[k] = i_frame_start ? in_x[k] : r_tile_x[k];
            eff_y[k] = i_frame_start ? in_y[k] : r_tile_y[k];
        end
    end

    always_ff @(posedge i_Clk)
    begin
        if (i_frame_start)
        begin
            r_tile_x <= in_x;
            r_tile_y <= in_y;
        end
    end

    // Hit test, later tiles win, so car 4 is on top
    always_comb
    begin
        hit_frog = 1'b0;
        hit_car  = 1'b0;
        hit_addr = '0;
        dx       = '0;
        dy       = '0;
        for (int k = 0; k < 5; k++)
        begin
            if (i_visible && i_h_count >= eff_x[k] && i_v_count >= eff_y[k] &&
                coord_t'(i_h_count - eff_x[k]) < TILE &&
                coord_t'(i_v_count - eff_y[k]) < TILE)
            begin
                dx       = i_h_count - eff_x[k];
                dy       = i_v_count - eff_y[k];
                hit_frog = (k == 0);
                hit_car  = (k != 0);
                hit_addr = sprite_addr_t'(dy * TILE + dx);
            end
        end
    end

    // Stage 1 address, payload only
    always_ff @(posedge i_Clk)
    begin
        o_rd_addr <= hit_addr;
    end

    assign pix = r_sel_car  ? i_car_pixel :
                 r_sel_frog ? i_frog_pixel : '0;

    always_ff @(posedge i_Clk)
    begin
        if (i_reset)
        begin
            o_frog_rd_en <= 1'b0;
            o_car_rd_en  <= 1'b0;
            r_sel_frog   <= 1'b0;
            r_sel_car    <= 1'b0;
            r_hs_pipe    <= '1;   // Syncs idle high
            r_vs_pipe    <= '1;
            o_vga_red    <= '0;
            o_vga_grn    <= '0;
            o_vga_blu    <= '0;
        end
        else
        begin
            o_frog_rd_en <= hit_frog;       // Stage 1
            o_car_rd_en  <= hit_car;
            r_sel_frog   <= o_frog_rd_en;   // Stage 2, tag follows the read
            r_sel_car    <= o_car_rd_en;
            o_vga_red    <= pix[8:6];       // Stage 3
            o_vga_grn    <= pix[5:3];
            o_vga_blu    <= pix[2:0];
            r_hs_pipe    <= {r_hs_pipe[1:0], i_hsync};
            r_vs_pipe    <= {r_vs_pipe[1:0], i_vsync};
        end
    end

    assign o_vga_hsync = r_hs_pipe[2];
    assign o_vga_vsync = r_vs_pipe[2];

    a_one_bank_read: assert property (@(posedge i_Clk) disable iff (i_reset)
        !(o_frog_rd_en && o_car_rd_en));

endmodule

`default_nettype wire

// File: source/frog_video_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "frog_video_defs.svh"

module frog_video_top
#(
    parameter int H_VISIBLE = `FV_H_VISIBLE,
    parameter int H_FRONT   = `FV_H_FRONT,
    parameter int H_SYNC    = `FV_H_SYNC,
    parameter int H_TOTAL   = `FV_H_TOTAL,
    parameter int V_VISIBLE = `FV_V_VISIBLE,
    parameter int V_FRONT   = `FV_V_FRONT,
    parameter int V_SYNC    = `FV_V_SYNC,
    parameter int V_TOTAL   = `FV_V_TOTAL
)
(
    input  wire                          i_Clk,
    input  wire                          i_reset,
    input  frog_video_pkg::coord_t       i_frog_x,
    input  frog_video_pkg::coord_t       i_frog_y,
    input  frog_video_pkg::coord_t       i_car1_x,
    input  frog_video_pkg::coord_t       i_car2_x,
    input  frog_video_pkg::coord_t       i_car3_x,
    input  frog_video_pkg::coord_t       i_car4_x,
    input  frog_video_pkg::coord_t       i_car1_y,
    input  frog_video_pkg::coord_t       i_car2_y,
    input  frog_video_pkg::coord_t       i_car3_y,
    input  frog_video_pkg::coord_t       i_car4_y,
    input  wire                          i_load_req,
    input  frog_video_pkg::bank_sel_t    i_load_bank,
    input  frog_video_pkg::sprite_addr_t i_load_addr,
    input  frog_video_pkg::pixel_t       i_load_data,
    output logic                         o_load_ack,
    output logic                         o_vga_hsync,
    output logic                         o_vga_vsync,
    output frog_video_pkg::chan_t        o_vga_red,
    output frog_video_pkg::chan_t        o_vga_grn,
    output frog_video_pkg::chan_t        o_vga_blu
);
    import frog_video_pkg::*;

    coord_t       h_count;
    coord_t       v_count;
    logic         hsync;
    logic         vsync;
    logic         visible;
    logic         blank;
    logic         frame_start;
    logic         frog_rd_en;
    logic         car_rd_en;
    sprite_addr_t rd_addr;
    pixel_t       frog_pixel;
    pixel_t       car_pixel;
    coord_t       car_x [4];
    coord_t       car_y [4];

    assign car_x[0] = i_car1_x;
    assign car_x[1] = i_car2_x;
    assign car_x[2] = i_car3_x;
    assign car_x[3] = i_car4_x;
    assign car_y[0] = i_car1_y;
    assign car_y[1] = i_car2_y;
    assign car_y[2] = i_car3_y;
    assign car_y[3] = i_car4_y;

    sprite_write_if wr_bus ();

    sprite_loader u_loader
    (
        .i_Clk       (i_Clk),
        .i_reset     (i_reset),
        .i_load_req  (i_load_req),
        .i_load_bank (i_load_bank),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .o_load_ack  (o_load_ack),
        .i_blank     (blank),
        .wr          (wr_bus.loader)
    );

    sprite_memory u_memory
    (
        .i_Clk        (i_Clk),
        .wr           (wr_bus.memory),
        .i_frog_rd_en (frog_rd_en),
        .i_car_rd_en  (car_rd_en),
        .i_rd_addr    (rd_addr),
        .o_frog_pixel (frog_pixel),
        .o_car_pixel  (car_pixel)
    );

    vga_timing #(
        .H_VISIBLE (H_VISIBLE),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_TOTAL   (H_TOTAL),
        .V_VISIBLE (V_VISIBLE),
        .V_FRONT   (V_FRONT),
        .V_SYNC    (V_SYNC),
        .V_TOTAL   (V_TOTAL)
    ) u_timing (
        .i_Clk         (i_Clk),
        .i_reset       (i_reset),
        .o_h_count     (h_count),
        .o_v_count     (v_count),
        .o_hsync       (hsync),
        .o_vsync       (vsync),
        .o_visible     (visible),
        .o_blank       (blank),
        .o_frame_start (frame_start)
    );

    sprite_display u_display
    (
        .i_Clk         (i_Clk),
        .i_reset       (i_reset),
        .i_h_count     (h_count),
        .i_v_count     (v_count),
        .i_visible     (visible),
        .i_frame_start (frame_start),
        .i_hsync       (hsync),
        .i_vsync       (vsync),
        .i_frog_x      (i_frog_x),
        .i_frog_y      (i_frog_y),
        .i_car_x       (car_x),
        .i_car_y       (car_y),
        .o_frog_rd_en  (frog_rd_en),
        .o_car_rd_en   (car_rd_en),
        .o_rd_addr     (rd_addr),
        .i_frog_pixel  (frog_pixel),
        .i_car_pixel   (car_pixel),
        .o_vga_hsync   (o_vga_hsync),
        .o_vga_vsync   (o_vga_vsync),
        .o_vga_red     (o_vga_red),
        .o_vga_grn     (o_vga_grn),
        .o_vga_blu     (o_vga_blu)
    );

endmodule

`default_nettype wire

// File: sim/frog_video_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "frog_video_defs.svh"

module frog_video_tb;
    import frog_video_pkg::*;

    // Reduced video mode
    localparam int H_VIS = 96;
    localparam int H_FP  = 4;
    localparam int H_SY  = 8;
    localparam int H_TOT = 112;
    localparam int V_VIS = 72;
    localparam int V_FP  = 2;
    localparam int V_SY  = 2;
    localparam int V_TOT = 80;
    localparam int TILE  = `FV_TILE_SIZE;
    localparam int FRAME_CYCLES = H_TOT * V_TOT;
    localparam int HS_TIMEOUT   = FRAME_CYCLES;   // Every frame has a blank window
    // About five blank cycles per word, spread over whole frames
    localparam int LOAD_CYCLES  = 2 * `FV_BANK_DEPTH * 5 * FRAME_CYCLES /
                                  (FRAME_CYCLES - H_VIS * V_VIS);
    localparam int TEST_FRAMES  = 14;
    localparam int CYCLE_LIMIT  = 2 * (LOAD_CYCLES + TEST_FRAMES * FRAME_CYCLES);

    logic         i_Clk;
    logic         i_reset;
    coord_t       tile_x [5];   // 0 is the frog, 1..4 the cars
    coord_t       tile_y [5];
    logic         load_req;
    bank_sel_t    load_bank;
    sprite_addr_t load_addr;
    pixel_t       load_data;
    logic         o_load_ack;
    logic         o_vga_hsync;
    logic         o_vga_vsync;
    chan_t        o_vga_red;
    chan_t        o_vga_grn;
    chan_t        o_vga_blu;

    // Reference model state
    logic [31:0]  rand_state = 32'h7f5c_c545;
    pixel_t       frog_mem [`FV_BANK_DEPTH];
    pixel_t       car_mem  [`FV_BANK_DEPTH];
    int           lat_x [5];
    int           lat_y [5];
    int           m_h;
    int           m_v;
    int           frame_count;
    int           run_cycles;
    pixel_t       exp_pix [3];   // Entry 2 is due at the outputs now
    logic         exp_hs [3];
    logic         exp_vs [3];
    int           exp_h [3];
    int           exp_v [3];
    logic         req_at_edge;
    logic         ack_seen = 1'b0;
    string        where_text;
    int           chan_errors = 0;
    int           sync_errors = 0;
    int           handshake_errors = 0;
    int           timeout_errors = 0;

    frog_video_top #(
        .H_VISIBLE (H_VIS),
        .H_FRONT   (H_FP),
        .H_SYNC    (H_SY),
        .H_TOTAL   (H_TOT),
        .V_VISIBLE (V_VIS),
        .V_FRONT   (V_FP),
        .V_SYNC    (V_SY),
        .V_TOTAL   (V_TOT)
    ) u_dut (
        .i_Clk       (i_Clk),
        .i_reset     (i_reset),
        .i_frog_x    (tile_x[0]),
        .i_frog_y    (tile_y[0]),
        .i_car1_x    (tile_x[1]),
        .i_car2_x    (tile_x[2]),
        .i_car3_x    (tile_x[3]),
        .i_car4_x    (tile_x[4]),
        .i_car1_y    (tile_y[1]),
        .i_car2_y    (tile_y[2]),
        .i_car3_y    (tile_y[3]),
        .i_car4_y    (tile_y[4]),
        .i_load_req  (load_req),
        .i_load_bank (load_bank),
        .i_load_addr (load_addr),
        .i_load_data (load_data),
        .o_load_ack  (o_load_ack),
        .o_vga_hsync (o_vga_hsync),
        .o_vga_vsync (o_vga_vsync),
        .o_vga_red   (o_vga_red),
        .o_vga_grn   (o_vga_grn),
        .o_vga_blu   (o_vga_blu)
    );

    initial
    begin
        i_Clk = 1'b0;
        forever #4 i_Clk = ~i_Clk;
    end

    function automatic logic [31:0] rand_next();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    // Later tiles are drawn on top, so car 4 wins
    function automatic pixel_t model_pixel(int h, int v);
        pixel_t       pix;
        sprite_addr_t addr;
        pix = '0;
        if (h < H_VIS && v < V_VIS)
        begin
            for (int k = 0; k < 5; k++)
            begin
                if (h >= lat_x[k] && h < lat_x[k] + TILE &&
                    v >= lat_y[k] && v < lat_y[k] + TILE)
                begin
                    addr = sprite_addr_t'((v - lat_y[k]) * TILE + h - lat_x[k]);
                    pix  = (k == 0) ? frog_mem[addr] : car_mem[addr];
                end
            end
        end
        return pix;
    endfunction

    task automatic check_chan(input chan_t got, input chan_t exp, input string what);
        if (got !== exp)
        begin
            chan_errors++;
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_sync(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            sync_errors++;
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Model raster, mirrors the DUT counters from reset release
    always @(posedge i_Clk)
    begin
        req_at_edge = load_req;
        if (i_reset)
        begin
            m_h         = 0;
            m_v         = 0;
            run_cycles  = 0;
            frame_count = 0;
            for (int i = 0; i < 3; i++)
            begin
                exp_pix[i] = '0;
                exp_hs[i]  = 1'b1;
                exp_vs[i]  = 1'b1;
                exp_h[i]   = 0;
                exp_v[i]   = 0;
            end
        end
        else
        begin
            if (m_h == 0 && m_v == 0)
            begin
                for (int k = 0; k < 5; k++)
                begin
                    lat_x[k] = int'(tile_x[k]);
                    lat_y[k] = int'(tile_y[k]);
                end
                frame_count++;
            end
            for (int i = 2; i > 0; i--)
            begin
                exp_pix[i] = exp_pix[i - 1];
                exp_hs[i]  = exp_hs[i - 1];
                exp_vs[i]  = exp_vs[i - 1];
                exp_h[i]   = exp_h[i - 1];
                exp_v[i]   = exp_v[i - 1];
            end
            exp_pix[0] = model_pixel(m_h, m_v);
            exp_hs[0]  = !(m_h >= H_VIS + H_FP && m_h < H_VIS + H_FP + H_SY);
            exp_vs[0]  = !(m_v >= V_VIS + V_FP && m_v < V_VIS + V_FP + V_SY);
            exp_h[0]   = m_h;
            exp_v[0]   = m_v;
            if (m_h == H_TOT - 1)
            begin
                m_h = 0;
                m_v = (m_v == V_TOT - 1) ? 0 : m_v + 1;
            end
            else
                m_h = m_h + 1;
            run_cycles++;
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge i_Clk)
    begin
        if (run_cycles > 0)
        begin
            where_text = $sformatf("at (%0d,%0d)", exp_h[2], exp_v[2]);
            check_chan(o_vga_red, exp_pix[2][8:6], {"red ", where_text});
            check_chan(o_vga_grn, exp_pix[2][5:3], {"green ", where_text});
            check_chan(o_vga_blu, exp_pix[2][2:0], {"blue ", where_text});
            check_sync(o_vga_hsync, exp_hs[2], {"hsync ", where_text});
            check_sync(o_vga_vsync, exp_vs[2], {"vsync ", where_text});
        end
    end

    // Four-phase order and the blanking rule on the ack
    always @(negedge i_Clk)
    begin
        if (o_load_ack && !ack_seen)
        begin
            if (!req_at_edge)
            begin
                handshake_errors++;
                $display("Load ack rose at %0t ns with no request pending", $time);
            end
            if (m_h < H_VIS && m_v < V_VIS)
            begin
                handshake_errors++;
                $display("Load ack rose at %0t ns while the raster is visible", $time);
            end
        end
        if (!o_load_ack && ack_seen && req_at_edge)
        begin
            handshake_errors++;
            $display("Load ack fell at %0t ns while the request was still high", $time);
        end
        ack_seen = o_load_ack;
    end

    // Called and returns at a falling edge
    task automatic load_word(input bank_sel_t bank, input sprite_addr_t addr,
                             input pixel_t data, output int latency);
        int waited;
        waited  = 0;
        latency = 0;
        if (o_load_ack)
        begin
            handshake_errors++;
            $display("Load ack still high when a new request was due at %0t ns", $time);
        end
        load_bank = bank;
        load_addr = addr;
        load_data = data;
        load_req  = 1'b1;
        while (!o_load_ack && waited < HS_TIMEOUT)
        begin
            @(negedge i_Clk);
            waited++;
        end
        if (!o_load_ack)
        begin
            handshake_errors++;
            $display("Handshake timeout, no ack for bank %0d word %0d", bank, addr);
            load_req = 1'b0;
            return;
        end
        if (waited < 2)
        begin
            handshake_errors++;
            $display("Load ack came after %0d cycles, less than two", waited);
        end
        latency = waited;
        if (bank)
            car_mem[addr] = data;
        else
            frog_mem[addr] = data;
        load_req = 1'b0;
        waited   = 0;
        while (o_load_ack && waited < HS_TIMEOUT)
        begin
            @(negedge i_Clk);
            waited++;
        end
        if (o_load_ack)
        begin
            handshake_errors++;
            $display("Handshake timeout, ack stayed high after the request fell");
        end
    endtask

    task automatic place_parked();
        for (int k = 0; k < 5; k++)
        begin
            tile_x[k] = coord_t'(1000);   // Right of every raster column
            tile_y[k] = coord_t'(1000);
        end
    endtask

    // Grid cells 40 apart, tiles never touch
    task automatic place_apart();
        for (int k = 0; k < 5; k++)
        begin
            tile_x[k] = coord_t'((k % 3) * 40 + rand_next() % 8);
            tile_y[k] = coord_t'((k / 3) * 40 + rand_next() % 8);
        end
    endtask

    task automatic place_overlapping();
        for (int k = 0; k < 5; k++)
        begin
            tile_x[k] = coord_t'(30 + rand_next() % 16);
            tile_y[k] = coord_t'(20 + rand_next() % 16);
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frame_count + n;
        while (frame_count < target)
            @(negedge i_Clk);
    endtask

    task automatic wait_for_pixel(input int h, input int v);
        while (!(m_h == h && m_v == v))
            @(negedge i_Clk);
    endtask

    task automatic end_run();
        $display("Errors: colour %0d, sync %0d, handshake %0d, timeout %0d",
                 chan_errors, sync_errors, handshake_errors, timeout_errors);
        if (chan_errors + sync_errors + handshake_errors + timeout_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    endtask

    initial
    begin
        int lat;
        i_reset   = 1'b1;
        load_req  = 1'b0;
        load_bank = 1'b0;
        load_addr = '0;
        load_data = '0;
        place_parked();
        repeat (10) @(negedge i_Clk);
        i_reset = 1'b0;

        wait_frames(2);   // Black screen, sync pulses only

        for (int b = 0; b < 2; b++)
        begin
            for (int a = 0; a < `FV_BANK_DEPTH; a++)
                load_word(bank_sel_t'(b), sprite_addr_t'(a), pixel_t'(rand_next()), lat);
        end

        place_apart();
        wait_frames(2);
        place_overlapping();
        wait_frames(2);

        // New positions halfway down, the frame must not tear
        wait_for_pixel(0, 36);
        place_apart();
        wait_frames(2);

        // Loads from inside the visible area
        wait_for_pixel(10, 4);
        load_word(bank_sel_t'(rand_next() % 2), sprite_addr_t'(rand_next()),
                  pixel_t'(rand_next()), lat);
        if (lat <= 2)
        begin
            handshake_errors++;
            $display("Load issued in the visible area was not held back");
        end
        for (int i = 0; i < 63; i++)
            load_word(bank_sel_t'(rand_next() % 2), sprite_addr_t'(rand_next()),
                      pixel_t'(rand_next()), lat);
        wait_frames(2);
        end_run();
    end

    initial
    begin
        repeat (CYCLE_LIMIT) @(posedge i_Clk);
        timeout_errors++;
        $display("Run stopped after %0d cycles with tests still running", CYCLE_LIMIT);
        end_run();
    end

endmodule

`default_nettype wire

// File: frog_video.f
+incdir+source
source/frog_video_pkg.sv
source/sprite_write_if.sv
source/sprite_loader.sv
source/sprite_memory.sv
source/vga_timing.sv
source/sprite_display.sv
source/frog_video_top.sv
sim/frog_video_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = frog_video_tb
FILELIST = frog_video.f
OBJ_DIR  = obj_dir
PASS_MSG = TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
